// ==== hw/game_pkg.sv ====
/*
 * Shared widths, game constants and the controller state encoding.
 * Every design file refers to these by scoped name.
 */
package game_pkg;

    // Balances and bet amounts
    typedef logic [7:0] money_t;

    // Wheel position and the player 2 guess
    typedef logic [3:0] wheel_t;

    // Remaining spin steps, up to 15 + MIN_SPIN
    typedef logic [4:0] spin_count_t;

    // Clock cycles within one spin step
    typedef logic [2:0] frame_count_t;

    // Each player starts with this much
    localparam money_t INITIAL_BALANCE = 8'd100;

    // Added to the low nibble of the bet to get the spin length
    localparam spin_count_t MIN_SPIN = 5'd4;

    // One wheel step per this many clocks
    localparam int FRAME_CYCLES = 8;

    // Main controller states, IDLE is entered on reset
    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOAD_AMOUNT = 3'd1,
        WAIT_AMOUNT = 3'd2,
        LOAD_KEY    = 3'd3,
        WAIT_START  = 3'd4,
        ANIMATE     = 3'd5
    } game_state_t;

endpackage

// ==== hw/game_ctrl_if.sv ====
/*
 * Control strobes between the game controller, the spin timer and the bank.
 * One instance lives in the top level and each block takes its own modport.
 */
`timescale 1ns/1ps

interface game_ctrl_if;

    logic load_amount;           // Player 1 is loading the bet
    logic load_key;              // Player 2 is loading the guess
    logic load_screen;           // Controller idle, refresh displays
    logic start_animation;       // Wheel is spinning
    logic finished_transaction;  // Last spin step, settle now

    // Sequencer side
    modport controller (
        output load_amount,
        output load_key,
        output load_screen,
        output start_animation,
        input  finished_transaction
    );

    // Runs the spin while start_animation is high
    modport timer (
        input  start_animation,
        output finished_transaction
    );

    // Datapath only listens
    modport bank (
        input load_amount,
        input load_key,
        input load_screen,
        input start_animation,
        input finished_transaction
    );

endinterface

// ==== hw/game_control.sv ====
/*
 * Main game sequencer. It steps through bet load, guess load, start and
 * spin, and decodes its state into the strobes for the timer and the bank.
 */
`timescale 1ns/1ps

module game_control (
    input  logic              clock,
    input  logic              resetn,
    input  logic              load_signal,
    input  logic              start_signal,
    game_ctrl_if.controller   ctrl
);

    game_pkg::game_state_t state_q;
    game_pkg::game_state_t state_d;

    // Next state table
    always_comb begin
        state_d = state_q;
        case (state_q)
            game_pkg::IDLE: begin
                if (load_signal) begin
                    state_d = game_pkg::LOAD_AMOUNT;
                end
            end
            game_pkg::LOAD_AMOUNT: begin
                if (!load_signal) begin
                    state_d = game_pkg::WAIT_AMOUNT;  // Bet held on release
                end
            end
            game_pkg::WAIT_AMOUNT: begin
                if (load_signal) begin
                    state_d = game_pkg::LOAD_KEY;
                end
            end
            game_pkg::LOAD_KEY: begin
                if (!load_signal) begin
                    state_d = game_pkg::WAIT_START;
                end
            end
            game_pkg::WAIT_START: begin
                if (start_signal) begin
                    state_d = game_pkg::ANIMATE;
                end
            end
            game_pkg::ANIMATE: begin
                // Load and start are ignored until the spin ends
                if (ctrl.finished_transaction) begin
                    state_d = game_pkg::IDLE;
                end
            end
            default: begin
                state_d = game_pkg::IDLE;
            end
        endcase
    end

    // Output decode, one strobe per state
    always_comb begin
        ctrl.load_amount     = 1'b0;
        ctrl.load_key        = 1'b0;
        ctrl.load_screen     = 1'b0;
        ctrl.start_animation = 1'b0;
        case (state_q)
            game_pkg::IDLE:        ctrl.load_screen     = 1'b1;
            game_pkg::LOAD_AMOUNT: ctrl.load_amount     = 1'b1;
            game_pkg::LOAD_KEY:    ctrl.load_key        = 1'b1;
            game_pkg::ANIMATE:     ctrl.start_animation = 1'b1;
            default: begin
                // Wait states drive nothing
            end
        endcase
    end

    // State register
    always_ff @(posedge clock) begin
        if (!resetn) begin
            state_q <= game_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// ==== hw/spin_timer.sv ====
/*
 * Spin timer. A frame prescaler gives one wheel step every FRAME_CYCLES
 * clocks, and a step counter ends the spin after (nibble + MIN_SPIN) steps.
 */
`timescale 1ns/1ps

module spin_timer (
    input  logic             clock,
    input  logic             resetn,
    game_ctrl_if.timer       ctrl,
    input  game_pkg::wheel_t spin_length,
    output logic             step
);

    logic                       anim_q;     // start_animation one clock ago
    logic                       first;      // First cycle of the spin
    game_pkg::frame_count_t     frame_q;
    game_pkg::frame_count_t     frame_cur;
    game_pkg::spin_count_t      steps_q;
    game_pkg::spin_count_t      steps_cur;
    game_pkg::spin_count_t      spin_total;

    assign first      = ctrl.start_animation && !anim_q;
    assign spin_total = game_pkg::spin_count_t'(spin_length) + game_pkg::MIN_SPIN;

    // On the first cycle the freshly loaded values are used directly
    assign frame_cur = first ? '0 : frame_q;
    assign steps_cur = first ? spin_total : steps_q;

    // Step on the last cycle of each frame
    assign step = ctrl.start_animation
                  && (frame_cur == game_pkg::frame_count_t'(game_pkg::FRAME_CYCLES - 1));

    // Last step also ends the round in the same cycle
    assign ctrl.finished_transaction = step && (steps_cur == game_pkg::spin_count_t'(1));

    always_ff @(posedge clock) begin
        if (!resetn) begin
            anim_q  <= 1'b0;
            frame_q <= '0;
            steps_q <= '0;
        end else begin
            anim_q <= ctrl.start_animation;
            if (ctrl.start_animation) begin
                frame_q <= frame_cur + game_pkg::frame_count_t'(1);  // Wraps each frame
                if (step) begin
                    steps_q <= steps_cur - game_pkg::spin_count_t'(1);
                end else begin
                    steps_q <= steps_cur;
                end
            end
        end
    end

endmodule

// ==== hw/bank_datapath.sv ====
/*
 * Game datapath. Holds the bet, the guess, the wheel and both balances,
 * settles each round toward the winner and latches the display copies.
 */
`timescale 1ns/1ps

module bank_datapath (
    input  logic              clock,
    input  logic              resetn,
    input  game_pkg::money_t  switches,
    game_ctrl_if.bank         ctrl,
    input  logic              step,
    output game_pkg::wheel_t  spin_length,
    output game_pkg::money_t  p1_display,
    output game_pkg::money_t  p2_display,
    output game_pkg::wheel_t  wheel_position
);

    game_pkg::money_t  bet_q;
    game_pkg::wheel_t  guess_q;
    game_pkg::wheel_t  wheel_q;
    game_pkg::wheel_t  wheel_next;
    game_pkg::money_t  p1_q;
    game_pkg::money_t  p2_q;
    game_pkg::money_t  p1_disp_q;
    game_pkg::money_t  p2_disp_q;
    game_pkg::money_t  loser_balance;
    game_pkg::money_t  transfer;
    logic              guess_hit;

    // Spin length comes from the bet's low nibble
    assign spin_length = bet_q[3:0];

    // Bet and guess follow the switches while their load strobe is high
    always_ff @(posedge clock) begin
        if (ctrl.load_amount) begin
            bet_q <= switches;
        end
        if (ctrl.load_key) begin
            guess_q <= switches[3:0];
        end
    end

    // Wheel value including the step of this cycle
    assign wheel_next = step ? wheel_q + game_pkg::wheel_t'(1) : wheel_q;

    always_ff @(posedge clock) begin
        if (!resetn) begin
            wheel_q <= '0;
        end else begin
            wheel_q <= wheel_next;  // Wraps modulo 16
        end
    end

    // A hit means player 2 wins, so player 1 pays
    assign guess_hit     = (guess_q == wheel_next);
    assign loser_balance = guess_hit ? p1_q : p2_q;

    // Never move more than the loser holds
    assign transfer = (bet_q < loser_balance) ? bet_q : loser_balance;

    // Balances settle at the last spin step
    always_ff @(posedge clock) begin
        if (!resetn) begin
            p1_q <= game_pkg::INITIAL_BALANCE;
            p2_q <= game_pkg::INITIAL_BALANCE;
        end else if (ctrl.finished_transaction) begin
            if (guess_hit) begin
                p1_q <= p1_q - transfer;
                p2_q <= p2_q + transfer;
            end else begin
                p1_q <= p1_q + transfer;
                p2_q <= p2_q - transfer;
            end
        end
    end

    /*
     * Display copies refresh while the controller is idle. They lag the
     * balances by one clock, and they hold steady through a round.
     */
    always_ff @(posedge clock) begin
        if (!resetn) begin
            p1_disp_q <= game_pkg::INITIAL_BALANCE;
            p2_disp_q <= game_pkg::INITIAL_BALANCE;
        end else if (ctrl.load_screen) begin
            p1_disp_q <= p1_q;
            p2_disp_q <= p2_q;
        end
    end

    assign p1_display     = p1_disp_q;
    assign p2_display     = p2_disp_q;
    assign wheel_position = wheel_q;

endmodule

// ==== hw/betting_game_top.sv ====
/*
 * Top level of the two-player betting game. It connects the controller,
 * the spin timer and the bank through one control interface.
 */
`timescale 1ns/1ps

module betting_game_top (
    input  logic              clock,
    input  logic              resetn,
    input  logic              load_signal,
    input  logic              start_signal,
    input  game_pkg::money_t  switches,
    output game_pkg::money_t  p1_display,
    output game_pkg::money_t  p2_display,
    output game_pkg::wheel_t  wheel_position,
    output logic              busy
);

    game_ctrl_if      ctrl_bus ();

    game_pkg::wheel_t spin_length;  // Bet nibble, bank to timer
    logic             step;         // One pulse per wheel step

    game_control i_game_control (
        .clock        (clock),
        .resetn       (resetn),
        .load_signal  (load_signal),
        .start_signal (start_signal),
        .ctrl         (ctrl_bus.controller)
    );

    spin_timer i_spin_timer (
        .clock       (clock),
        .resetn      (resetn),
        .ctrl        (ctrl_bus.timer),
        .spin_length (spin_length),
        .step        (step)
    );

    bank_datapath i_bank_datapath (
        .clock          (clock),
        .resetn         (resetn),
        .switches       (switches),
        .ctrl           (ctrl_bus.bank),
        .step           (step),
        .spin_length    (spin_length),
        .p1_display     (p1_display),
        .p2_display     (p2_display),
        .wheel_position (wheel_position)
    );

    // Spin in progress
    assign busy = ctrl_bus.start_animation;

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * Testbench clock and reset source. Gives a 10 ns clock and holds
 * resetn low for the first three cycles.
 */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clock,
    output logic resetn
);

    localparam int HALF_PERIOD  = 5;  // ns
    localparam int RESET_CYCLES = 3;

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        resetn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
    end

endmodule

// ==== verification/tb_betting_game.sv ====
/*
 * Testbench for the betting game top level. Plays directed and random
 * rounds, predicts each stop position and settlement, and checks them.
 */
`timescale 1ns/1ps

module tb_betting_game;

    localparam int          MAX_ROUNDS      = 20;
    localparam int          ROUND_CYCLES    = 200;
    localparam int          WATCHDOG_CYCLES = MAX_ROUNDS * ROUND_CYCLES;
    localparam int          RANDOM_ROUNDS   = 12;
    localparam logic [31:0] RANDOM_SEED     = 32'h3606_3029;

    logic              clock;
    logic              resetn;
    logic              load_signal;
    logic              start_signal;
    game_pkg::money_t  switches;
    game_pkg::money_t  p1_display;
    game_pkg::money_t  p2_display;
    game_pkg::wheel_t  wheel_position;
    logic              busy;

    int exp_p1;     // Model balances
    int exp_p2;
    int exp_wheel;  // Model wheel position
    int error_count;

    tb_clock_gen i_clock_gen (
        .clock  (clock),
        .resetn (resetn)
    );

    betting_game_top i_dut (
        .clock          (clock),
        .resetn         (resetn),
        .load_signal    (load_signal),
        .start_signal   (start_signal),
        .switches       (switches),
        .p1_display     (p1_display),
        .p2_display     (p2_display),
        .wheel_position (wheel_position),
        .busy           (busy)
    );

    task automatic report_mismatch(input string name, input int actual, input int expected);
        error_count++;
        $display("CHECK FAILED at time %0t: %s is %0d, expected %0d", $time, name, actual,
                 expected);
        $display("ERRORS FOUND");
        $fatal(1, "Stopping at first mismatch");
    endtask

    task automatic report_failure(input string what);
        error_count++;
        $display("At time %0t: %s", $time, what);
        $display("ERRORS FOUND");
        $fatal(1, "Stopping at first failure");
    endtask

    // Wheel moves by the bet nibble plus the minimum spin
    function automatic int stop_after(input int bet);
        return (exp_wheel + (bet % 16) + int'(game_pkg::MIN_SPIN)) % 16;
    endfunction

    // Sum of the shown balances never changes
    balance_sum: assert property (@(posedge clock) disable iff (!resetn)
        (int'(p1_display) + int'(p2_display)) == 2 * int'(game_pkg::INITIAL_BALANCE))
        else report_mismatch("p1_display + p2_display",
                             int'(p1_display) + int'(p2_display),
                             2 * int'(game_pkg::INITIAL_BALANCE));

    // No wheel movement outside a spin
    wheel_idle: assert property (@(posedge clock) disable iff (!resetn)
        !busy |=> $stable(wheel_position))
        else report_failure("wheel_position moved while no spin was running");

    task automatic play_round(input int bet, input int guess, input bit disturb);
        int  spin_cycles;
        int  stop;
        int  loser;
        int  transfer;
        int  busy_cycles;
        int  wait_count;
        bit  hit;
        spin_cycles = ((bet % 16) + int'(game_pkg::MIN_SPIN)) * game_pkg::FRAME_CYCLES;
        stop        = stop_after(bet);

        // Player 1 loads the bet over two clocks
        @(negedge clock);
        switches    = game_pkg::money_t'(bet);
        load_signal = 1'b1;
        repeat (2) @(negedge clock);
        load_signal = 1'b0;

        // Player 2 loads the guess
        @(negedge clock);
        switches    = game_pkg::money_t'(guess);
        load_signal = 1'b1;
        repeat (2) @(negedge clock);
        load_signal = 1'b0;

        @(negedge clock);
        start_signal = 1'b1;
        @(negedge clock);
        start_signal = 1'b0;

        wait_count = 0;
        while (!busy) begin
            wait_count++;
            if (wait_count > 4) begin
                report_failure("busy did not rise after the start pulse");
            end
            @(negedge clock);
        end

        busy_cycles = 0;
        while (busy) begin
            busy_cycles++;
            if (disturb) begin
                // Stray presses mid-spin that release long before the end
                load_signal  = (busy_cycles >= 3) && (busy_cycles < 6);
                start_signal = (busy_cycles >= 4) && (busy_cycles < 7);
                if (busy_cycles == 3) begin
                    switches = ~switches;
                end
            end
            if (busy_cycles > spin_cycles) begin
                report_failure("busy stayed high past the predicted spin length");
            end
            @(negedge clock);
        end
        repeat (2) @(negedge clock);  // Displays refresh after settlement

        // Reference settlement
        hit      = ((guess % 16) == stop);
        loser    = hit ? exp_p1 : exp_p2;
        transfer = (bet < loser) ? bet : loser;
        if (hit) begin
            exp_p1 = exp_p1 - transfer;
            exp_p2 = exp_p2 + transfer;
        end else begin
            exp_p1 = exp_p1 + transfer;
            exp_p2 = exp_p2 - transfer;
        end
        exp_wheel = stop;

        assert (busy_cycles == spin_cycles)
            else report_mismatch("busy high cycles", busy_cycles, spin_cycles);
        assert (int'(wheel_position) == exp_wheel)
            else report_mismatch("wheel_position", int'(wheel_position), exp_wheel);
        assert (int'(p1_display) == exp_p1)
            else report_mismatch("p1_display", int'(p1_display), exp_p1);
        assert (int'(p2_display) == exp_p2)
            else report_mismatch("p2_display", int'(p2_display), exp_p2);
    endtask

    initial begin
        int bet;
        int guess;
        load_signal  = 1'b0;
        start_signal = 1'b0;
        switches     = '0;
        error_count  = 0;
        exp_p1       = int'(game_pkg::INITIAL_BALANCE);
        exp_p2       = int'(game_pkg::INITIAL_BALANCE);
        exp_wheel    = 0;
        void'($urandom(RANDOM_SEED));

        @(posedge resetn);
        @(negedge clock);
        assert (int'(p1_display) == exp_p1)
            else report_mismatch("p1_display", int'(p1_display), exp_p1);
        assert (int'(p2_display) == exp_p2)
            else report_mismatch("p2_display", int'(p2_display), exp_p2);
        assert (wheel_position == '0)
            else report_mismatch("wheel_position", int'(wheel_position), 0);
        assert (busy == 1'b0)
            else report_mismatch("busy", int'(busy), 0);

        play_round(10, stop_after(10), 1'b0);             // Hit so p1 pays
        play_round(5, (stop_after(5) + 1) % 16, 1'b0);    // Miss so p2 pays
        play_round(200, (stop_after(200) + 3) % 16, 1'b0); // Miss clamped to p2
        play_round(250, stop_after(250), 1'b0);           // Hit clamped to p1
        play_round(33, (stop_after(33) + 7) % 16, 1'b1);  // Presses during the spin

        for (int n = 0; n < RANDOM_ROUNDS; n++) begin
            bet = int'($urandom_range(255, 0));
            if ($urandom_range(1, 0) == 1) begin
                guess = stop_after(bet);
            end else begin
                guess = int'($urandom_range(15, 0));
            end
            play_round(bet, guess, (n % 4) == 3);
        end

        if (error_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "Run ended with failed checks");
        end
    end

    // Bounds the whole run
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

endmodule

// ==== src.f ====
hw/game_pkg.sv
hw/game_ctrl_if.sv
hw/game_control.sv
hw/spin_timer.sv
hw/bank_datapath.sv
hw/betting_game_top.sv
verification/tb_clock_gen.sv
verification/tb_betting_game.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the betting game testbench with Verilator and runs it.
# The run passes only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=tb_betting_game

verilator --binary --timing --assert -j 0 \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "NO ERRORS" "$LOG_FILE"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
